// ==== common/farm_pkg.sv ====
// Shared byte, sensor, alert, LED and FSM state types plus sensor packet protocol constants
`default_nettype none

package farm_pkg;

  // ==========================================================================
  // Basic data types
  // ==========================================================================

  typedef logic [7:0] byte_t;          // One UART byte
  typedef logic [1:0] sensor_level_t;  // Quantized reading, bits 1:0 of the byte

  localparam sensor_level_t OPTIMAL_LEVEL = 2'd2;

  // Readings of one accepted packet
  typedef struct packed {
    sensor_level_t temp;
    sensor_level_t humidity;
    sensor_level_t light;
    sensor_level_t soil;
    byte_t         fault_flags;  // Nonzero means co-processor fault
  } sensor_frame_t;

  // Alert severity, higher is worse
  typedef enum logic [2:0] {
    ALERT_SUBOPTIMAL = 3'd2,
    ALERT_HARVEST    = 3'd6,
    ALERT_FAULT      = 3'd7
  } alert_level_e;

  // Packed MSB first, so temp_ok lands on bit 0
  typedef struct packed {
    logic csum_error;   // Bit 6
    logic fault;
    logic harvest;
    logic soil_ok;
    logic light_ok;
    logic humidity_ok;
    logic temp_ok;      // Bit 0
  } status_leds_t;

  // ==========================================================================
  // FSM states
  // ==========================================================================

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_e;  // Both UART FSMs

  // One state per packet byte
  typedef enum logic [2:0] {
    HEADER, TEMP, HUMIDITY, LIGHT, SOIL, FAULTS, ACTUATOR, CHECKSUM
  } parse_state_e;

  // Protocol bytes
  localparam byte_t PKT_HEADER = 8'hAA;
  localparam byte_t ACK_BYTE   = 8'h55;  // Checksum good
  localparam byte_t NAK_BYTE   = 8'hEE;  // Checksum bad

endpackage

`default_nettype wire

// ==== dv/tb_checks.svh ====
// Error counters and typed compare tasks for the farm monitor testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ============================================================================
// Error counters
// ============================================================================

int mismatch_count = 0;  // Wrong values
int failure_count  = 0;  // Timeouts and framing problems

// One compare task per result type

task automatic check_byte(input string name, input byte_t got, input byte_t exp);
  if (got !== exp) begin
    mismatch_count++;
    $display("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
  end
endtask

task automatic check_alert(input string name, input alert_level_e got,
                           input alert_level_e exp);
  if (got !== exp) begin
    mismatch_count++;
    $display("mismatch %s: got 0x%01h, expected 0x%01h", name, got, exp);
  end
endtask

task automatic check_leds(input string name, input status_leds_t got,
                          input status_leds_t exp);
  if (got !== exp) begin
    mismatch_count++;
    $display("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);  // Bit 0 is temp_ok
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    mismatch_count++;
    $display("mismatch %s: got 0x%01h, expected 0x%01h", name, got, exp);
  end
endtask

`endif

// ==== dv/tb_farm_monitor.sv ====
// Farm monitor testbench with clock, reset, serial driver, reply decoder, model and test sequence
`default_nettype none
`timescale 1ns/1ns

module tb_farm_monitor import farm_pkg::*; ();

  localparam int CLKS_PER_BIT  = 16;
  localparam int DRIVE_DLY     = 2;                      // ns after rising edge
  localparam int SEED          = 36;
  localparam int REPLY_TIMEOUT = 12 * 10 * CLKS_PER_BIT;  // Cycles, covers a whole packet
  localparam int N_GOOD        = 20;
  localparam int N_BAD         = 4;
  localparam int N_JUNK        = 3;

  logic          clk;
  logic          rst_n;
  logic          uart_rx;
  logic          uart_tx;
  logic          harvest_alert;
  alert_level_e  alert_level;
  status_leds_t  status_leds;
  logic          fault_detected;

  sensor_frame_t model_frame;  // Last accepted readings
  logic          model_csum;   // Sticky checksum error
  byte_t         pkt [0:7];    // Packet being sent
  status_leds_t  cap_leds;     // Outputs captured at reply start bit
  alert_level_e  cap_alert;
  logic          cap_harvest;
  logic          cap_fault;
  int            n;
  int            junk_n;

  `include "tb_checks.svh"

  farm_monitor_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .uart_rx       (uart_rx),
    .uart_tx       (uart_tx),
    .harvest_alert (harvest_alert),
    .alert_level   (alert_level),
    .status_leds   (status_leds),
    .fault_detected(fault_detected)
  );

  always #20 clk = ~clk;  // 40 ns period

  // ==========================================================================
  // Reference model
  // ==========================================================================

  function automatic status_leds_t expected_leds(input sensor_frame_t f, input logic csum);
    status_leds_t e;
    e.temp_ok     = (f.temp == OPTIMAL_LEVEL);
    e.humidity_ok = (f.humidity == OPTIMAL_LEVEL);
    e.light_ok    = (f.light == OPTIMAL_LEVEL);
    e.soil_ok     = (f.soil == OPTIMAL_LEVEL);
    e.harvest     = e.temp_ok && e.humidity_ok && e.light_ok && e.soil_ok;
    e.fault       = (f.fault_flags != 8'h00);
    e.csum_error  = csum;
    return e;
  endfunction

  function automatic alert_level_e expected_alert(input status_leds_t e);
    if (e.fault) return ALERT_FAULT;      // Fault first
    if (e.harvest) return ALERT_HARVEST;
    return ALERT_SUBOPTIMAL;
  endfunction

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  // Random upper bits, level in bits 1:0
  function automatic byte_t reading_byte(input logic optimal);
    byte_t b;
    b = byte_t'($urandom);
    if (optimal) b[1:0] = OPTIMAL_LEVEL;
    else if (b[1:0] == OPTIMAL_LEVEL) b[1:0] = 2'd3;
    return b;
  endfunction

  function automatic byte_t random_flags();
    if ($urandom % 4 == 0) return byte_t'($urandom | 32'h1);  // Rare fault, never zero
    return 8'h00;
  endfunction

  task automatic build_packet(input logic all_optimal, input byte_t flags);
    byte_t sum;
    int i;
    pkt[0] = PKT_HEADER;
    for (i = 1; i <= 4; i++) begin
      pkt[i] = reading_byte(all_optimal || ($urandom % 2 == 0));  // About half optimal
    end
    pkt[5] = flags;
    pkt[6] = byte_t'($urandom);  // Actuator status
    sum = 8'h00;
    for (i = 1; i <= 6; i++) sum = sum + pkt[i];
    pkt[7] = sum;
  endtask

  // 8N1, LSB first
  task automatic send_byte(input byte_t b);
    logic [9:0] bits;
    int i;
    bits = {1'b1, b, 1'b0};
    @(posedge clk);
    #DRIVE_DLY;
    for (i = 0; i < 10; i++) begin
      uart_rx = bits[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  task automatic send_packet();
    int i;
    for (i = 0; i < 8; i++) send_byte(pkt[i]);
  endtask

  task automatic send_junk(input int count);
    byte_t b;
    int i;
    for (i = 0; i < count; i++) begin
      b = byte_t'($urandom);
      if (b == PKT_HEADER) b = 8'h00;
      send_byte(b);
    end
  endtask

  // ==========================================================================
  // Reply decoder, samples on falling edges
  // ==========================================================================

  task automatic receive_reply(output byte_t b, output logic ok);
    int cycles;
    int i;
    ok     = 1'b0;
    b      = 8'h00;
    cycles = 0;
    @(negedge clk);
    while (uart_tx !== 1'b0 && cycles < REPLY_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (uart_tx !== 1'b0) begin
      failure_count++;
      $display("no reply start bit on uart_tx within %0d cycles", REPLY_TIMEOUT);
    end else begin
      cap_leds    = status_leds;  // Outputs settled before start bit
      cap_alert   = alert_level;
      cap_harvest = harvest_alert;
      cap_fault   = fault_detected;
      repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);  // Centre of start bit
      if (uart_tx !== 1'b0) begin
        failure_count++;
        $display("start bit on uart_tx ended before its centre");
      end
      for (i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        b[i] = uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (uart_tx !== 1'b1) begin
        failure_count++;
        $display("stop bit on uart_tx was low");
      end
      ok = 1'b1;
    end
  endtask

  task automatic watch_quiet(input int cycles);
    int i;
    logic seen;
    seen = 1'b0;
    for (i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (uart_tx !== 1'b1) seen = 1'b1;
    end
    if (seen) begin
      failure_count++;
      $display("uart_tx sent a reply to bytes outside a packet");
    end
  endtask

  // Send pkt, decode reply, update model, compare
  task automatic run_packet(input logic good);
    byte_t got;
    logic ok;
    status_leds_t exp_leds;
    fork
      send_packet();
      receive_reply(got, ok);
    join
    if (good) begin
      model_frame.temp        = pkt[1][1:0];
      model_frame.humidity    = pkt[2][1:0];
      model_frame.light       = pkt[3][1:0];
      model_frame.soil        = pkt[4][1:0];
      model_frame.fault_flags = pkt[5];
      model_csum              = 1'b0;
    end else begin
      model_csum = 1'b1;  // Readings unchanged
    end
    exp_leds = expected_leds(model_frame, model_csum);
    if (ok) begin
      check_byte("reply", got, good ? ACK_BYTE : NAK_BYTE);
      check_leds("status_leds", cap_leds, exp_leds);
      check_alert("alert_level", cap_alert, expected_alert(exp_leds));
      check_bit("harvest_alert", cap_harvest, exp_leds.harvest);
      check_bit("fault_detected", cap_fault, exp_leds.fault);
    end
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    uart_rx     = 1'b1;  // Line idle
    model_frame = '0;
    model_csum  = 1'b0;
    void'($urandom(SEED));
    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("uart_tx", uart_tx, 1'b1);
    check_bit("harvest_alert", harvest_alert, 1'b0);
    check_bit("fault_detected", fault_detected, 1'b0);
    check_leds("status_leds", status_leds, '0);
    check_alert("alert_level", alert_level, ALERT_SUBOPTIMAL);

    for (n = 0; n < N_GOOD; n++) begin
      build_packet(1'b0, random_flags());
      run_packet(1'b1);
    end

    // Bad checksum, then a good packet clears the LED
    for (n = 0; n < N_BAD; n++) begin
      build_packet(1'b0, random_flags());
      pkt[7] = pkt[7] ^ byte_t'(1 + $urandom % 255);
      run_packet(1'b0);
      build_packet(1'b0, random_flags());
      run_packet(1'b1);
    end

    // Junk ahead of a packet
    for (n = 0; n < N_JUNK; n++) begin
      junk_n = 1 + int'($urandom % 4);
      fork
        send_junk(junk_n);
        watch_quiet(junk_n * 11 * CLKS_PER_BIT + 4 * CLKS_PER_BIT);
      join
      build_packet(1'b0, random_flags());
      run_packet(1'b1);
    end

    // Fault outranks harvest
    build_packet(1'b1, 8'h81);
    run_packet(1'b1);
    check_alert("alert_level", cap_alert, ALERT_FAULT);
    check_bit("harvest_alert", cap_harvest, 1'b1);
    check_bit("fault_detected", cap_fault, 1'b1);
    build_packet(1'b1, 8'h00);
    run_packet(1'b1);
    check_alert("alert_level", cap_alert, ALERT_HARVEST);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count + failure_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/farm_monitor_top.sv ====
// Farm monitor top level with UART receiver, packet parser, harvest decision and transmitter
`default_nettype none
`timescale 1ns/1ns

module farm_monitor_top import farm_pkg::*; #(
  parameter int CLKS_PER_BIT = 868  // 100 MHz at 115200 baud
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         uart_rx,         // From co-processor
  output logic         uart_tx,         // ACK or NAK per packet
  output logic         harvest_alert,
  output alert_level_e alert_level,
  output status_leds_t status_leds,
  output logic         fault_detected
);

  byte_t         rx_data;
  logic          rx_valid;
  sensor_frame_t frame;
  logic          frame_valid;
  logic          csum_error;
  byte_t         reply_data;
  logic          reply_valid;
  logic          reply_ready;

  // ==========================================================================
  // Receive path
  // ==========================================================================

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (uart_rx),
    .rx_data (rx_data),
    .rx_valid(rx_valid)
  );

  packet_parser u_parser (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .frame      (frame),
    .frame_valid(frame_valid),
    .csum_error (csum_error),
    .reply_data (reply_data),
    .reply_valid(reply_valid),
    .reply_ready(reply_ready)
  );

  harvest_decision u_decision (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame         (frame),
    .frame_valid   (frame_valid),
    .csum_error    (csum_error),
    .harvest_alert (harvest_alert),
    .alert_level   (alert_level),
    .status_leds   (status_leds),
    .fault_detected(fault_detected)
  );

  // Reply path back to co-processor
  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_data (reply_data),
    .tx_valid(reply_valid),
    .tx_ready(reply_ready),
    .tx      (uart_tx)
  );

endmodule

`default_nettype wire

// ==== hw/harvest_decision.sv ====
// Harvest decision with registered alert level, status LEDs and fault outputs
`default_nettype none
`timescale 1ns/1ns

module harvest_decision import farm_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  sensor_frame_t frame,
  input  logic          frame_valid,
  input  logic          csum_error,
  output logic          harvest_alert,
  output alert_level_e  alert_level,
  output status_leds_t  status_leds,
  output logic          fault_detected
);

  status_leds_t leds_next;
  alert_level_e alert_next;
  logic         update;

  // ==========================================================================
  // Decision from the accepted readings
  // ==========================================================================

  always_comb begin
    leds_next.temp_ok     = (frame.temp == OPTIMAL_LEVEL);
    leds_next.humidity_ok = (frame.humidity == OPTIMAL_LEVEL);
    leds_next.light_ok    = (frame.light == OPTIMAL_LEVEL);
    leds_next.soil_ok     = (frame.soil == OPTIMAL_LEVEL);
    // All four optimal
    leds_next.harvest     = leds_next.temp_ok && leds_next.humidity_ok &&
                            leds_next.light_ok && leds_next.soil_ok;
    leds_next.fault       = |frame.fault_flags;
    // Sticky until the next good packet
    leds_next.csum_error  = csum_error;  // Only loaded on update
  end

  // Fault outranks harvest
  always_comb begin
    if (leds_next.fault) begin
      alert_next = ALERT_FAULT;
    end else if (leds_next.harvest) begin
      alert_next = ALERT_HARVEST;
    end else begin
      alert_next = ALERT_SUBOPTIMAL;
    end
  end

  assign update = frame_valid || csum_error;

  // ==========================================================================
  // Output registers
  // ==========================================================================

  // Zero frame after reset is suboptimal
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_leds <= '0;
      alert_level <= ALERT_SUBOPTIMAL;
    end else if (update) begin
      status_leds <= leds_next;
      alert_level <= alert_next;
    end
  end

  assign harvest_alert  = status_leds.harvest;
  assign fault_detected = status_leds.fault;

endmodule

`default_nettype wire

// ==== hw/packet_parser.sv ====
// Sensor packet parser with checksum check, accepted reading register and reply request
`default_nettype none
`timescale 1ns/1ns

module packet_parser import farm_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  byte_t         rx_data,
  input  logic          rx_valid,
  output sensor_frame_t frame,        // Last accepted readings
  output logic          frame_valid,  // Pulse per good packet
  output logic          csum_error,   // Pulse per bad packet
  output byte_t         reply_data,
  output logic          reply_valid,
  input  logic          reply_ready
);

  parse_state_e  state;
  sensor_frame_t shadow;  // Readings of the packet in flight
  byte_t         sum;     // Running sum of bytes 1 to 6
  logic          csum_ok;

  assign csum_ok = (rx_data == sum);

  // ==========================================================================
  // Packet FSM, one state per byte
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= HEADER;
      sum   <= '0;
    end else if (rx_valid) begin
      // Payload bytes all count toward the sum
      if (state != HEADER && state != CHECKSUM) sum <= sum + rx_data;
      case (state)
        HEADER: begin
          sum <= '0;
          if (rx_data == PKT_HEADER) state <= TEMP;  // Junk between packets dropped
        end
        TEMP:     state <= HUMIDITY;
        HUMIDITY: state <= LIGHT;
        LIGHT:    state <= SOIL;
        SOIL:     state <= FAULTS;
        FAULTS:   state <= ACTUATOR;
        ACTUATOR: state <= CHECKSUM;  // Actuator status unused
        CHECKSUM: state <= HEADER;
        default:  state <= HEADER;
      endcase
    end
  end

  // Shadow frame, payload only
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      case (state)
        TEMP:     shadow.temp        <= rx_data[1:0];
        HUMIDITY: shadow.humidity    <= rx_data[1:0];
        LIGHT:    shadow.light       <= rx_data[1:0];
        SOIL:     shadow.soil        <= rx_data[1:0];
        FAULTS:   shadow.fault_flags <= rx_data;
        default:  ;
      endcase
    end
  end

  // ==========================================================================
  // Commit and reply
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame       <= '0;
      frame_valid <= 1'b0;
      csum_error  <= 1'b0;
      reply_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      csum_error  <= 1'b0;
      if (reply_valid && reply_ready) reply_valid <= 1'b0;  // Accepted by transmitter
      // Later packet wins over a pending reply
      if (rx_valid && state == CHECKSUM) begin
        reply_valid <= 1'b1;
        if (csum_ok) begin
          frame       <= shadow;
          frame_valid <= 1'b1;
        end else begin
          csum_error <= 1'b1;  // Old readings kept
        end
      end
    end
  end

  // Reply byte held while reply_valid is up
  always_ff @(posedge clk) begin
    if (rx_valid && state == CHECKSUM) begin
      reply_data <= csum_ok ? ACK_BYTE : NAK_BYTE;
    end
  end

endmodule

`default_nettype wire

// ==== hw/uart/uart_bit_timer.sv ====
// UART bit timer giving full-bit or half-bit ticks after a restart
`default_nettype none
`timescale 1ns/1ns

module uart_bit_timer #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic clk,
  input  logic rst_n,
  input  logic restart,  // Hold counter at zero
  input  logic half,     // Tick after half a bit
  output logic tick
);

  // Counter just wide enough for CLKS_PER_BIT - 1
  localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CW-1:0] FULL_LAST = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF_LAST = CW'((CLKS_PER_BIT - 1) / 2);

  logic [CW-1:0] count;
  logic [CW-1:0] last;  // Terminal count for this bit

  assign last = half ? HALF_LAST : FULL_LAST;
  assign tick = !restart && (count == last);

  // Wraps on tick so back-to-back bits need no restart
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (restart || tick) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/uart/uart_rx.sv ====
// UART receiver with input synchronizer, 8N1 receive FSM and byte pulse output
`default_nettype none
`timescale 1ns/1ns

module uart_rx import farm_pkg::*; #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx,        // Serial in, idle high
  output byte_t rx_data,   // Valid with rx_valid
  output logic  rx_valid   // One-cycle pulse per good byte
);

  uart_state_e state;
  logic        rx_meta;
  logic        rx_sync;
  logic [2:0]  bit_cnt;   // Data bit index
  byte_t       rx_shift;  // LSB arrives first
  logic        bit_tick;

  // ==========================================================================
  // Two-flop synchronizer, resets to idle level
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // Half-bit wait in START puts later samples at bit centres
  uart_bit_timer #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_bit_timer (
    .clk    (clk),
    .rst_n  (rst_n),
    .restart(state == IDLE),
    .half   (state == START),
    .tick   (bit_tick)
  );

  assign rx_data = rx_shift;  // Stable from stop bit until next data bit

  // ==========================================================================
  // Receive FSM
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        IDLE: begin
          bit_cnt <= '0;
          if (!rx_sync) state <= START;  // Falling edge
        end
        START: begin
          if (bit_tick) state <= rx_sync ? IDLE : DATA;  // Glitch means false start
        end
        DATA: begin
          if (bit_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= STOP;
          end
        end
        STOP: begin
          if (bit_tick) begin
            rx_valid <= rx_sync;  // Framing error drops the byte
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Shift register is payload only
  always_ff @(posedge clk) begin
    if (state == DATA && bit_tick) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
  end

endmodule

`default_nettype wire

// ==== hw/uart/uart_tx.sv ====
// UART transmitter with valid/ready byte input and 8N1 transmit FSM
`default_nettype none
`timescale 1ns/1ns

module uart_tx import farm_pkg::*; #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic  clk,
  input  logic  rst_n,
  input  byte_t tx_data,
  input  logic  tx_valid,
  output logic  tx_ready,  // High only in IDLE
  output logic  tx         // Serial out, idle high
);

  uart_state_e state;
  logic [2:0]  bit_cnt;
  byte_t       tx_shift;  // Remaining data bits
  logic        bit_tick;
  logic        xfer;

  assign tx_ready = (state == IDLE);
  assign xfer     = tx_valid && tx_ready;

  uart_bit_timer #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_bit_timer (
    .clk    (clk),
    .rst_n  (rst_n),
    .restart(state == IDLE),
    .half   (1'b0),          // Full bits only
    .tick   (bit_tick)
  );

  // ==========================================================================
  // Transmit FSM, tx registered so each level lasts one full bit
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      bit_cnt <= '0;
      tx      <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          bit_cnt <= '0;
          tx      <= 1'b1;
          if (xfer) begin
            tx    <= 1'b0;   // Start bit next cycle
            state <= START;
          end
        end
        START: begin
          if (bit_tick) begin
            tx    <= tx_shift[0];  // Data bit 0
            state <= DATA;
          end
        end
        DATA: begin
          if (bit_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              tx    <= 1'b1;  // Stop bit
              state <= STOP;
            end else begin
              tx <= tx_shift[0];
            end
          end
        end
        STOP: begin
          if (bit_tick) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Latch on transfer, shift after each data bit is launched
  always_ff @(posedge clk) begin
    if (xfer) begin
      tx_shift <= tx_data;
    end else if (bit_tick && (state == START || state == DATA)) begin
      tx_shift <= {1'b1, tx_shift[7:1]};
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+dv
common/farm_pkg.sv
hw/uart/uart_bit_timer.sv
hw/uart/uart_rx.sv
hw/uart/uart_tx.sv
hw/packet_parser.sv
hw/harvest_decision.sv
hw/farm_monitor_top.sv
dv/tb_farm_monitor.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the farm monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns \
  --top-module tb_farm_monitor -f list.f

./obj_dir/Vtb_farm_monitor > "$LOG" 2>&1
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
exit 0
